/* logic/wavebuf_cfg.svh */
`ifndef WAVEBUF_CFG_SVH
`define WAVEBUF_CFG_SVH

// sample and word geometry
`define WB_SAMPLE_W      12
`define WB_TAG_W         4
`define WB_LANES         8
`define WB_CHANNELS      4
`define WB_WORD_W        512

// control field widths
`define WB_LEN_W         14
`define WB_CYCLE_W       14
`define WB_DELAY_W       20
`define WB_EVENT_W       16
`define WB_MODE_W        4

// delay floor and the data mode that keeps only trailers
`define WB_DELAY_MIN     8
`define WB_MODE_RAW_OFF  1

// 496-bit marker patterns below the event number
`define WB_HEADER_MARK  {240'h0b0c1234567887654321aa5500eb55aaeb011234567887654321aa5501eb, \
                         256'h55aaeb021234567887654321aa5502eb55aaeb031234567887654321aa5503eb}
`define WB_TRAILER_MARK {240'heb041234567887654321aa5502eb55aaeb031234567887654321aa5505eb, \
                         128'h55aaeb061234567887654321aa5506eb, \
                         128'h55aaeb031234567887654321aa5507eb}

// settings after reset
`define WB_LEN_RESET     1000
`define WB_CYCLE_RESET   1000
`define WB_DELAY_RESET   8

`endif

/* logic/wavebuf_pkg.sv */
`include "wavebuf_cfg.svh"

package wavebuf_pkg;

    // one-hot channel code in the low nibble of every sample lane
    typedef enum logic [`WB_TAG_W-1:0] {
        CH1 = 4'b0001,
        CH2 = 4'b0010,
        CH3 = 4'b0100,
        CH4 = 4'b1000
    } chan_tag_e;

    typedef enum logic [1:0] {
        WORD_HEADER  = 2'd0,
        WORD_SAMPLE  = 2'd1,
        WORD_TRAILER = 2'd2
    } word_kind_e;

    typedef struct packed {
        logic [`WB_SAMPLE_W-1:0] sample;
        chan_tag_e               tag;
    } sample_lane_t;

    // event number on top, fixed pattern below
    typedef struct packed {
        logic [`WB_EVENT_W-1:0]            event_no;
        logic [`WB_WORD_W-`WB_EVENT_W-1:0] pattern;
    } marker_word_t;

    // one output word, read by its kind as lanes or as a marker
    typedef union packed {
        sample_lane_t [`WB_WORD_W/(`WB_SAMPLE_W+`WB_TAG_W)-1:0] lanes;
        marker_word_t                                           marker;
    } frame_word_u;

endpackage

/* logic/ctrl_if.sv */
`timescale 1ns/1ns
`include "wavebuf_cfg.svh"

// synchronised control, input side to sequencer
interface ctrl_if;

    logic                   start;
    logic                   trig;
    logic                   fifo_full;
    logic [`WB_LEN_W-1:0]   wave_len;
    logic [`WB_CYCLE_W-1:0] cycles;
    logic [`WB_DELAY_W-1:0] delay;
    logic                   raw_off;

    modport src (
        output start, trig, fifo_full, wave_len, cycles, delay, raw_off
    );

    modport dst (
        input  start, trig, fifo_full, wave_len, cycles, delay, raw_off
    );

endinterface

/* logic/ctrl_sync.sv */
`timescale 1ns/1ns
`include "wavebuf_cfg.svh"

module ctrl_sync (
    input  logic                   clk_125M,
    input  logic                   reset,
    input  logic                   dma_start_i,
    input  logic                   trig_i,
    input  logic                   prog_full_i,
    input  logic [`WB_LEN_W-1:0]   wave_len_i,
    input  logic [`WB_CYCLE_W-1:0] cycle_i,
    input  logic [`WB_DELAY_W-1:0] delay_i,
    input  logic [`WB_MODE_W-1:0]  data_mode_i,
    ctrl_if.src                    ctrl
);

    localparam logic [`WB_DELAY_W-1:0] DELAY_MIN = `WB_DELAY_MIN;

    // first and second register stage
    logic                   start_q1, start_q2;
    logic                   trig_q1, trig_q2;
    logic                   full_q1, full_q2;
    logic [`WB_LEN_W-1:0]   len_q1, len_q2;
    logic [`WB_CYCLE_W-1:0] cycle_q1, cycle_q2;
    logic [`WB_DELAY_W-1:0] delay_q1, delay_q2;
    logic [`WB_MODE_W-1:0]  mode_q1, mode_q2;

    always_ff @(posedge clk_125M or posedge reset) begin
        if (reset) begin
            start_q1 <= 1'b0;
            start_q2 <= 1'b0;
            trig_q1  <= 1'b0;
            trig_q2  <= 1'b0;
            full_q1  <= 1'b0;
            full_q2  <= 1'b0;
            len_q1   <= `WB_LEN_RESET;
            len_q2   <= `WB_LEN_RESET;
            cycle_q1 <= `WB_CYCLE_RESET;
            cycle_q2 <= `WB_CYCLE_RESET;
            delay_q1 <= `WB_DELAY_RESET;
            delay_q2 <= `WB_DELAY_RESET;
            mode_q1  <= '0;
            mode_q2  <= '0;
        end else begin
            start_q1 <= dma_start_i;
            start_q2 <= start_q1;
            trig_q1  <= trig_i;
            trig_q2  <= trig_q1;
            full_q1  <= prog_full_i;
            full_q2  <= full_q1;
            len_q1   <= wave_len_i;
            len_q2   <= len_q1;
            cycle_q1 <= cycle_i;
            cycle_q2 <= cycle_q1;
            // clamp on entry so both stages stay at or above the floor
            delay_q1 <= (delay_i < DELAY_MIN) ? DELAY_MIN : delay_i;
            delay_q2 <= delay_q1;
            mode_q1  <= data_mode_i;
            mode_q2  <= mode_q1;
        end
    end

    assign ctrl.start     = start_q2;
    assign ctrl.trig      = trig_q2;
    assign ctrl.fifo_full = full_q2;
    assign ctrl.wave_len  = len_q2;
    assign ctrl.cycles    = cycle_q2;
    assign ctrl.delay     = delay_q2;
    assign ctrl.raw_off   = (mode_q2 == `WB_MODE_RAW_OFF);

    a_delay_floor: assert property (
        @(posedge clk_125M) disable iff (reset) ctrl.delay >= DELAY_MIN
    );

endmodule

/* logic/capture_seq.sv */
`timescale 1ns/1ns
`include "wavebuf_cfg.svh"

module capture_seq (
    input  logic                   clk_125M,
    input  logic                   reset,
    ctrl_if.dst                    ctrl,
    output logic                   word_stb_o,
    output wavebuf_pkg::word_kind_e word_kind_o,
    output logic [`WB_EVENT_W-1:0] event_no_o
);

    import wavebuf_pkg::*;

    localparam int EVENT_W = `WB_EVENT_W;
    // frame length in 512-bit words is wave_len / 8
    localparam int WCNT_W  = `WB_LEN_W - 3;

    ////////////////////////////////////////
    // one-hot states
    ////////////////////////////////////////

    localparam logic [7:0] ST_IDLE    = 8'b0000_0001;
    localparam logic [7:0] ST_ARM     = 8'b0000_0010;
    localparam logic [7:0] ST_DELAY   = 8'b0000_0100;
    localparam logic [7:0] ST_HEADER  = 8'b0000_1000;
    localparam logic [7:0] ST_TX      = 8'b0001_0000;
    localparam logic [7:0] ST_TRAILER = 8'b0010_0000;
    localparam logic [7:0] ST_EMPTY   = 8'b0100_0000;
    localparam logic [7:0] ST_DONE    = 8'b1000_0000;

    logic [7:0]             state_q;
    logic [7:0]             state_d;
    logic [`WB_DELAY_W-1:0] delay_cnt_q;
    logic [WCNT_W-1:0]      word_cnt_q;
    logic [WCNT_W-1:0]      sample_words;
    logic [EVENT_W-1:0]     event_cnt_q;
    logic                   burst_end;

    // words between header and trailer
    assign sample_words = ctrl.wave_len[`WB_LEN_W-1:3] - WCNT_W'(2);
    assign burst_end    = (event_cnt_q == EVENT_W'(ctrl.cycles));

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (ctrl.start) begin
                    state_d = ST_ARM;
                end
            end
            ST_ARM: begin
                if (ctrl.trig && !ctrl.fifo_full) begin
                    state_d = ST_DELAY;
                end
            end
            ST_DELAY: begin
                // counter runs 0..delay, so delay+1 cycles here
                if (delay_cnt_q == ctrl.delay) begin
                    state_d = ST_HEADER;
                end
            end
            ST_HEADER: begin
                state_d = (sample_words == '0) ? ST_TRAILER : ST_TX;
            end
            ST_TX: begin
                if (word_cnt_q == sample_words - WCNT_W'(1)) begin
                    state_d = ST_TRAILER;
                end
            end
            ST_TRAILER: begin
                state_d = ST_EMPTY;
            end
            ST_EMPTY: begin
                state_d = burst_end ? ST_DONE : ST_ARM;
            end
            ST_DONE: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    ////////////////////////////////////////
    // state and counters
    ////////////////////////////////////////

    always_ff @(posedge clk_125M or posedge reset) begin
        if (reset) begin
            state_q     <= ST_IDLE;
            delay_cnt_q <= '0;
            word_cnt_q  <= '0;
            event_cnt_q <= '0;
        end else begin
            state_q <= state_d;

            if (state_q == ST_DELAY) begin
                delay_cnt_q <= delay_cnt_q + 1'b1;
            end else begin
                delay_cnt_q <= '0;
            end

            if (state_q == ST_TX) begin
                word_cnt_q <= word_cnt_q + 1'b1;
            end else begin
                word_cnt_q <= '0;
            end

            // trailer still sees the old number, the bump lands with it
            if (state_q == ST_TRAILER) begin
                event_cnt_q <= event_cnt_q + 1'b1;
            end else if (state_q == ST_DONE) begin
                event_cnt_q <= '0;
            end
        end
    end

    // raw-off keeps only the trailer
    assign word_stb_o = ((state_q == ST_HEADER || state_q == ST_TX) && !ctrl.raw_off)
                        || (state_q == ST_TRAILER);

    always_comb begin
        case (state_q)
            ST_HEADER:  word_kind_o = WORD_HEADER;
            ST_TRAILER: word_kind_o = WORD_TRAILER;
            default:    word_kind_o = WORD_SAMPLE;
        endcase
    end

    assign event_no_o = event_cnt_q;

    a_state_onehot: assert property (
        @(posedge clk_125M) disable iff (reset) $onehot(state_q)
    );

    a_no_stb_waiting: assert property (
        @(posedge clk_125M) disable iff (reset)
        (state_q == ST_IDLE || state_q == ST_ARM) |-> !word_stb_o
    );

endmodule

/* logic/frame_packer.sv */
`timescale 1ns/1ns
`include "wavebuf_cfg.svh"

module frame_packer (
    input  logic                               clk_125M,
    input  logic                               reset,
    input  logic                               word_stb_i,
    input  wavebuf_pkg::word_kind_e            word_kind_i,
    input  logic [`WB_EVENT_W-1:0]             event_no_i,
    input  logic [`WB_LANES*`WB_SAMPLE_W-1:0]  ch1_data_i,
    input  logic [`WB_LANES*`WB_SAMPLE_W-1:0]  ch2_data_i,
    input  logic [`WB_LANES*`WB_SAMPLE_W-1:0]  ch3_data_i,
    input  logic [`WB_LANES*`WB_SAMPLE_W-1:0]  ch4_data_i,
    output logic [`WB_WORD_W-1:0]              adc_data_o,
    output logic                               adc_data_valid_o
);

    import wavebuf_pkg::*;

    localparam int N_LANES = `WB_WORD_W / (`WB_SAMPLE_W + `WB_TAG_W);
    localparam chan_tag_e CH_TAG [`WB_CHANNELS] = '{CH1, CH2, CH3, CH4};

    logic [`WB_LANES*`WB_SAMPLE_W-1:0] ch_data [`WB_CHANNELS];
    frame_word_u                       word_d;
    frame_word_u                       word_q;
    logic                              valid_q;

    assign ch_data[0] = ch1_data_i;
    assign ch_data[1] = ch2_data_i;
    assign ch_data[2] = ch3_data_i;
    assign ch_data[3] = ch4_data_i;

    ////////////////////////////////////////
    // word build
    ////////////////////////////////////////

    always_comb begin
        word_d = '0;
        case (word_kind_i)
            WORD_HEADER: begin
                word_d.marker.event_no = event_no_i;
                word_d.marker.pattern  = `WB_HEADER_MARK;
            end
            WORD_TRAILER: begin
                word_d.marker.event_no = event_no_i;
                word_d.marker.pattern  = `WB_TRAILER_MARK;
            end
            default: begin
                // ch1 lane 0 in the top lane, ch4 lane 7 at the bottom
                for (int c = 0; c < `WB_CHANNELS; c++) begin
                    for (int l = 0; l < `WB_LANES; l++) begin
                        word_d.lanes[N_LANES-1-(c*`WB_LANES+l)].sample =
                            ch_data[c][l*`WB_SAMPLE_W +: `WB_SAMPLE_W];
                        word_d.lanes[N_LANES-1-(c*`WB_LANES+l)].tag = CH_TAG[c];
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk_125M or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= word_stb_i;
        end
    end

    always_ff @(posedge clk_125M) begin
        if (word_stb_i) begin
            word_q <= word_d;
        end
    end

    assign adc_data_o       = word_q;
    assign adc_data_valid_o = valid_q;

    // one header per frame, the sequencer never repeats it
    a_single_header: assert property (
        @(posedge clk_125M) disable iff (reset)
        (word_stb_i && word_kind_i == WORD_HEADER)
        |=> !(word_stb_i && word_kind_i == WORD_HEADER)
    );

endmodule

/* logic/adc_wavebuf.sv */
`timescale 1ns/1ns
`include "wavebuf_cfg.svh"

module adc_wavebuf (
    input  logic                              clk_125M,
    input  logic                              reset,
    input  logic                              dma_start_i,
    input  logic                              trig_i,
    input  logic                              prog_full_i,
    input  logic [`WB_LEN_W-1:0]              wave_len_i,
    input  logic [`WB_CYCLE_W-1:0]            cycle_i,
    input  logic [`WB_DELAY_W-1:0]            delay_i,
    input  logic [`WB_MODE_W-1:0]             data_mode_i,
    input  logic [`WB_LANES*`WB_SAMPLE_W-1:0] ch1_data_i,
    input  logic [`WB_LANES*`WB_SAMPLE_W-1:0] ch2_data_i,
    input  logic [`WB_LANES*`WB_SAMPLE_W-1:0] ch3_data_i,
    input  logic [`WB_LANES*`WB_SAMPLE_W-1:0] ch4_data_i,
    output logic [`WB_WORD_W-1:0]             adc_data_o,
    output logic                              adc_data_valid_o
);

    import wavebuf_pkg::*;

    ctrl_if ctrl_bus ();

    logic                   word_stb;
    word_kind_e             word_kind;
    logic [`WB_EVENT_W-1:0] event_no;

    ctrl_sync i_ctrl_sync (
        .clk_125M    (clk_125M),
        .reset       (reset),
        .dma_start_i (dma_start_i),
        .trig_i      (trig_i),
        .prog_full_i (prog_full_i),
        .wave_len_i  (wave_len_i),
        .cycle_i     (cycle_i),
        .delay_i     (delay_i),
        .data_mode_i (data_mode_i),
        .ctrl        (ctrl_bus.src)
    );

    capture_seq i_capture_seq (
        .clk_125M    (clk_125M),
        .reset       (reset),
        .ctrl        (ctrl_bus.dst),
        .word_stb_o  (word_stb),
        .word_kind_o (word_kind),
        .event_no_o  (event_no)
    );

    frame_packer i_frame_packer (
        .clk_125M         (clk_125M),
        .reset            (reset),
        .word_stb_i       (word_stb),
        .word_kind_i      (word_kind),
        .event_no_i       (event_no),
        .ch1_data_i       (ch1_data_i),
        .ch2_data_i       (ch2_data_i),
        .ch3_data_i       (ch3_data_i),
        .ch4_data_i       (ch4_data_i),
        .adc_data_o       (adc_data_o),
        .adc_data_valid_o (adc_data_valid_o)
    );

endmodule

/* sim/tb_adc_wavebuf.sv */
`timescale 1ns/1ns
`include "wavebuf_cfg.svh"

module tb_adc_wavebuf;

    import wavebuf_pkg::*;

    // rough length of each test in cycles
    localparam int T_SHAPE = 50;
    localparam int T_PACK  = 60;
    localparam int T_DELAY = 100;
    localparam int T_BURST = 110;
    localparam int T_RAW   = 70;
    localparam int TIMEOUT_CYCLES = (8 + T_SHAPE + T_PACK + T_DELAY + T_BURST + T_RAW) * 4;
    localparam int LW = `WB_LANES * `WB_SAMPLE_W;

    logic                   clk_125M = 1'b0;
    logic                   reset;
    logic                   dma_start_i;
    logic                   trig_i;
    logic                   prog_full_i;
    logic [`WB_LEN_W-1:0]   wave_len_i;
    logic [`WB_CYCLE_W-1:0] cycle_i;
    logic [`WB_DELAY_W-1:0] delay_i;
    logic [`WB_MODE_W-1:0]  data_mode_i;
    logic [LW-1:0]          ch1_data_i;
    logic [LW-1:0]          ch2_data_i;
    logic [LW-1:0]          ch3_data_i;
    logic [LW-1:0]          ch4_data_i;
    logic [`WB_WORD_W-1:0]  adc_data_o;
    logic                   adc_data_valid_o;

    integer                seed = 32'h20f8f8af;
    logic [11:0]           adc_cnt;
    int                    cycle_cnt = 0;
    int                    trig_cycle = 0;
    int                    checks = 0;
    int                    errors = 0;
    logic [`WB_WORD_W-1:0] words_q [$];
    int                    stamps_q [$];

    adc_wavebuf i_dut (.*);

    always #4 clk_125M = ~clk_125M;

    ////////////////////////////////////////
    // ADC model, monitor and timeout
    ////////////////////////////////////////

    // lane value is counter + lane + 8 * channel
    function automatic logic [LW-1:0] channel_word(input logic [11:0] base, input int c);
        logic [LW-1:0] r;
        for (int l = 0; l < `WB_LANES; l++) begin
            r[l*`WB_SAMPLE_W +: `WB_SAMPLE_W] = 12'(base + l + 8 * c);
        end
        return r;
    endfunction

    always @(negedge clk_125M) begin
        adc_cnt = adc_cnt + 12'd1;
        ch1_data_i = channel_word(adc_cnt, 0);
        ch2_data_i = channel_word(adc_cnt, 1);
        ch3_data_i = channel_word(adc_cnt, 2);
        ch4_data_i = channel_word(adc_cnt, 3);
    end

    always @(negedge clk_125M) begin
        if (adc_data_valid_o === 1'b1) begin
            words_q.push_back(adc_data_o);
            stamps_q.push_back(cycle_cnt);
        end
    end

    always @(posedge clk_125M) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles without the expected output words",
                     cycle_cnt);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_eq(input logic [`WB_WORD_W-1:0] actual,
                            input logic [`WB_WORD_W-1:0] expected, input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
        end
    endtask

    ////////////////////////////////////////
    // burst helpers
    ////////////////////////////////////////

    task automatic apply_settings(input int len, input int cyc, input int dly, input int mode);
        @(negedge clk_125M);
        wave_len_i  = len;
        cycle_i     = cyc;
        delay_i     = dly;
        data_mode_i = mode;
        repeat (3) @(negedge clk_125M);
    endtask

    // sequencer sits in arm once this returns
    task automatic start_burst();
        words_q.delete();
        stamps_q.delete();
        dma_start_i = 1'b1;
        @(negedge clk_125M);
        dma_start_i = 1'b0;
        repeat (5) @(negedge clk_125M);
    endtask

    task automatic raise_trig();
        trig_i = 1'b1;
        trig_cycle = cycle_cnt + 1;
    endtask

    task automatic wait_words(input int n);
        while (words_q.size() < n) begin
            @(posedge clk_125M);
        end
    endtask

    task automatic end_burst(input int n, input string what);
        repeat (6) @(negedge clk_125M);
        trig_i      = 1'b0;
        prog_full_i = 1'b0;
        check_eq(words_q.size(), n, {what, " word count"});
        repeat (4) @(negedge clk_125M);
    endtask

    task automatic check_marker(input int idx, input bit is_header, input int ev,
                                input string what);
        frame_word_u w;
        w = words_q[idx];
        check_eq(w.marker.event_no, ev, {what, " event number"});
        if (is_header) begin
            check_eq(w.marker.pattern, `WB_HEADER_MARK, {what, " header pattern"});
        end else begin
            check_eq(w.marker.pattern, `WB_TRAILER_MARK, {what, " trailer pattern"});
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%s finished with %0d mismatches", name, errors - err_before);
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic test_frame_shape();
        int e0;
        e0 = errors;
        apply_settings(64, 1, 10, 0);
        start_burst();
        raise_trig();
        wait_words(8);
        end_burst(8, "frame shape");
        check_marker(0, 1'b1, 0, "first word");
        check_marker(7, 1'b0, 0, "last word");
        report_test("frame shape", e0);
    endtask

    task automatic test_sample_packing();
        frame_word_u w;
        logic [11:0] base;
        logic [11:0] prev;
        int          e0;
        e0 = errors;
        prev = '0;
        apply_settings(96, 1, 8, 0);
        start_burst();
        raise_trig();
        wait_words(12);
        end_burst(12, "sample packing");
        for (int i = 1; i <= 10; i++) begin
            w = words_q[i];
            base = w.lanes[31].sample;
            if (i > 1) begin
                check_eq(base, 12'(prev + 1), $sformatf("word %0d step", i));
            end
            for (int k = 0; k < 32; k++) begin
                check_eq(w.lanes[31-k].tag, 4'b0001 << (k / 8),
                         $sformatf("word %0d lane %0d tag", i, k));
                // top lane is the reference for the others
                if (k > 0) begin
                    check_eq(w.lanes[31-k].sample, 12'(base + k),
                             $sformatf("word %0d lane %0d sample", i, k));
                end
            end
            prev = base;
        end
        report_test("sample packing", e0);
    endtask

    task automatic test_delay();
        int dly [2] = '{20, 3};
        int lat;
        int e0;
        e0 = errors;
        foreach (dly[j]) begin
            apply_settings(32, 1, dly[j], 0);
            start_burst();
            raise_trig();
            wait_words(4);
            lat = stamps_q[0] - trig_cycle;
            end_burst(4, "delay");
            check_marker(0, 1'b1, 0, "delayed header");
            // delay below the floor is raised to it
            check_eq(lat, ((dly[j] < `WB_DELAY_MIN) ? `WB_DELAY_MIN : dly[j]) + 4,
                     $sformatf("header latency for delay %0d", dly[j]));
        end
        report_test("delay", e0);
    endtask

    task automatic test_multi_event();
        int e0;
        e0 = errors;
        apply_settings(32, 3, 8, 0);
        prog_full_i = 1'b1;
        start_burst();
        raise_trig();
        repeat (20) @(negedge clk_125M);
        check_eq(words_q.size(), 0, "words while FIFO full");
        prog_full_i = 1'b0;
        wait_words(12);
        end_burst(12, "multi event");
        for (int ev = 0; ev < 3; ev++) begin
            check_marker(ev * 4, 1'b1, ev, $sformatf("event %0d header", ev));
            check_marker(ev * 4 + 3, 1'b0, ev, $sformatf("event %0d trailer", ev));
        end
        report_test("multi event", e0);
    endtask

    task automatic test_raw_off();
        int e0;
        e0 = errors;
        apply_settings(32, 2, 8, `WB_MODE_RAW_OFF);
        start_burst();
        raise_trig();
        wait_words(2);
        end_burst(2, "raw off");
        check_marker(0, 1'b0, 0, "raw off event 0");
        check_marker(1, 1'b0, 1, "raw off event 1");
        report_test("raw off", e0);
    endtask

    initial begin
        reset       = 1'b1;
        dma_start_i = 1'b0;
        trig_i      = 1'b0;
        prog_full_i = 1'b0;
        wave_len_i  = `WB_LEN_RESET;
        cycle_i     = `WB_CYCLE_RESET;
        delay_i     = `WB_DELAY_RESET;
        data_mode_i = '0;
        adc_cnt     = 12'($random(seed));
        ch1_data_i  = channel_word(adc_cnt, 0);
        ch2_data_i  = channel_word(adc_cnt, 1);
        ch3_data_i  = channel_word(adc_cnt, 2);
        ch4_data_i  = channel_word(adc_cnt, 3);
        repeat (8) @(negedge clk_125M);
        reset = 1'b0;
        check_eq(adc_data_valid_o, 1'b0, "valid after reset");
        test_frame_shape();
        test_sample_packing();
        test_delay();
        test_multi_event();
        test_raw_off();
        $display("%0d checks run, %0d mismatches", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+logic
logic/wavebuf_pkg.sv
logic/ctrl_if.sv
logic/ctrl_sync.sv
logic/capture_seq.sv
logic/frame_packer.sv
logic/adc_wavebuf.sv
sim/tb_adc_wavebuf.sv

/* Bender.yml */
package:
  name: adc_wavebuf

sources:
  - include_dirs:
      - logic
    files:
      - logic/wavebuf_pkg.sv
      - logic/ctrl_if.sv
      - logic/ctrl_sync.sv
      - logic/capture_seq.sv
      - logic/frame_packer.sv
      - logic/adc_wavebuf.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/tb_adc_wavebuf.sv
